/* hw/bridge_settings.svh */
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// sram windows, byte addresses
`define BASE_RAM_START    32'h8000_0000  // base sram, shared with fetch
`define EXT_RAM_START     32'h8040_0000  // ext sram, load/store only
`define RAM_SPAN_BITS     22             // 4 MB per window

// word address width of one sram chip
`define SRAM_ADDR_W       20

// serial port registers
`define UART_DATA_ADDR    32'hBFD0_03F8  // rx byte on read, tx byte on write
`define UART_STAT_ADDR    32'hBFD0_03FC  // read only

// status word layout
`define STAT_TX_READY_BIT 0              // transmitter idle
`define STAT_RX_AVAIL_BIT 1              // received byte waiting

`endif

/* hw/bridge_pkg.sv */
`default_nettype none

`include "bridge_settings.svh"

package bridge_pkg;

    // one load/store request, held by the master until lsu_resp_o
    typedef struct packed {
        logic        valid;  // request present
        logic        we;     // 1 = write, 0 = read
        logic [31:0] addr;   // byte address
        logic [31:0] wdata;
        logic [3:0]  be_n;   // byte enables, active low
    } lsu_req_t;

    // pins of one asynchronous sram, data split into two directions
    typedef struct packed {
        logic [`SRAM_ADDR_W-1:0] addr;  // word address
        logic [31:0]             wdata;
        logic [3:0]              be_n;
        logic                    ce_n;  // chip select
        logic                    oe_n;  // output enable for reads
        logic                    we_n;  // write strobe, sampled on the rising edge
    } sram_bus_t;

endpackage

`default_nettype wire

/* hw/map_pkg.sv */
`default_nettype none

`include "bridge_settings.svh"

package map_pkg;

    typedef enum logic [2:0] {
        REGION_NONE,       // unmapped, reads 0
        REGION_BASE,
        REGION_EXT,
        REGION_UART_DATA,
        REGION_UART_STAT
    } region_t;

    // byte address -> target, uart registers matched per word
    function automatic region_t decode_region(input logic [31:0] addr);
        region_t region;
        region = REGION_NONE;
        if ((addr >> `RAM_SPAN_BITS) == (`BASE_RAM_START >> `RAM_SPAN_BITS)) begin
            region = REGION_BASE;
        end else if ((addr >> `RAM_SPAN_BITS) == (`EXT_RAM_START >> `RAM_SPAN_BITS)) begin
            region = REGION_EXT;
        end else if ((addr >> 2) == (`UART_DATA_ADDR >> 2)) begin
            region = REGION_UART_DATA;
        end else if ((addr >> 2) == (`UART_STAT_ADDR >> 2)) begin
            region = REGION_UART_STAT;
        end
        return region;
    endfunction

endpackage

`default_nettype wire

/* hw/uart_buffer.sv */
`timescale 1ns/10ps
`default_nettype none

module uart_buffer (
    input  wire logic       clk_i,
    input  wire logic       rst_i,

    // from the arbiter
    input  wire logic       uart_wr_i,     // accepted data write
    input  wire logic       uart_rd_i,     // accepted data read
    input  wire logic [7:0] uart_wdata_i,

    // byte level receiver strobes
    input  wire logic       uart_rx_ready_i,  // one cycle per byte
    input  wire logic [7:0] uart_rx_data_i,

    // back to the arbiter
    output logic      [7:0] rx_byte_o,
    output logic            rx_avail_o,

    // byte level transmitter
    output logic      [7:0] uart_tx_data_o,
    output logic            uart_tx_start_o
);

    logic [7:0] rx_buf;
    logic       rx_avail;
    logic [7:0] tx_buf;
    logic       tx_start;

    // received byte, a new arrival overwrites
    always_ff @(posedge clk_i) begin
        if (uart_rx_ready_i) begin
            rx_buf <= uart_rx_data_i;
        end
    end

    // available flag
    // set by the receiver, cleared by a data read
    // new byte in the same cycle as a read keeps it set
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rx_avail <= 1'b0;
        end else if (uart_rx_ready_i) begin
            rx_avail <= 1'b1;
        end else if (uart_rd_i) begin
            rx_avail <= 1'b0;  // byte consumed
        end
    end

    // transmit byte, latched on the accepted write
    always_ff @(posedge clk_i) begin
        if (uart_wr_i) begin
            tx_buf <= uart_wdata_i;
        end
    end

    // start strobe, high for the cycle after the write
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            tx_start <= 1'b0;
        end else begin
            tx_start <= uart_wr_i;
        end
    end

    assign rx_byte_o       = rx_buf;
    assign rx_avail_o      = rx_avail;
    assign uart_tx_data_o  = tx_buf;
    assign uart_tx_start_o = tx_start;

endmodule

`default_nettype wire

/* hw/bus_arbiter.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bridge_settings.svh"

module bus_arbiter
    import bridge_pkg::*;
    import map_pkg::*;
(
    // fetch port, reads base sram only
    input  wire logic        fetch_req_i,
    input  wire logic [31:0] fetch_addr_i,
    output logic      [31:0] fetch_rdata_o,
    output logic             fetch_resp_o,

    // load/store port
    input  wire lsu_req_t    lsu_req_i,
    output logic      [31:0] lsu_rdata_o,
    output logic             lsu_resp_o,

    // sram pins
    output sram_bus_t        base_sram_o,
    input  wire logic [31:0] base_sram_rdata_i,
    output sram_bus_t        ext_sram_o,
    input  wire logic [31:0] ext_sram_rdata_i,

    // serial buffer side
    input  wire logic [7:0]  rx_byte_i,
    input  wire logic        rx_avail_i,
    input  wire logic        tx_ready_i,
    output logic             uart_wr_o,    // accepted data write
    output logic             uart_rd_o,    // accepted data read
    output logic      [7:0]  uart_wdata_o
);

    region_t     lsu_region;
    logic        lsu_base;    // load/store owns base sram this cycle
    logic        lsu_ext;
    logic        lsu_udata;
    logic        fetch_sel;   // fetch gets base sram
    logic        tx_stall;    // data write while transmitter busy
    logic [31:0] stat_word;

    // one sram pin bundle from a selected access
    function automatic sram_bus_t make_bus(
        input logic        sel,
        input logic        wr,
        input logic [31:0] byte_addr,
        input logic [31:0] wdata,
        input logic [3:0]  be_n
    );
        sram_bus_t bus;
        bus.addr  = byte_addr[`SRAM_ADDR_W+1:2];  // drop byte offset
        bus.wdata = wdata;
        bus.be_n  = be_n;
        bus.ce_n  = ~sel;
        bus.oe_n  = ~(sel & ~wr);
        bus.we_n  = ~(sel & wr);
        return bus;
    endfunction

    assign lsu_region = decode_region(lsu_req_i.addr);

    assign lsu_base  = lsu_req_i.valid && (lsu_region == REGION_BASE);
    assign lsu_ext   = lsu_req_i.valid && (lsu_region == REGION_EXT);
    assign lsu_udata = lsu_req_i.valid && (lsu_region == REGION_UART_DATA);

    // load/store wins the base sram, fetch waits on its response
    assign fetch_sel    = fetch_req_i & ~lsu_base;
    assign fetch_resp_o = fetch_sel;

    assign base_sram_o = make_bus(
        lsu_base | fetch_sel,
        lsu_base & lsu_req_i.we,
        lsu_base ? lsu_req_i.addr : fetch_addr_i,
        lsu_req_i.wdata,
        lsu_base ? lsu_req_i.be_n : 4'b0000     // fetch reads whole words
    );

    assign ext_sram_o = make_bus(
        lsu_ext,
        lsu_req_i.we,
        lsu_req_i.addr,
        lsu_req_i.wdata,
        lsu_req_i.be_n
    );

    assign fetch_rdata_o = base_sram_rdata_i;  // async sram, same cycle

    // status register, everything else reads 0
    always_comb begin
        stat_word                     = '0;
        stat_word[`STAT_TX_READY_BIT] = tx_ready_i;
        stat_word[`STAT_RX_AVAIL_BIT] = rx_avail_i;
    end

    always_comb begin
        case (lsu_region)
            REGION_BASE:      lsu_rdata_o = base_sram_rdata_i;
            REGION_EXT:       lsu_rdata_o = ext_sram_rdata_i;
            REGION_UART_DATA: lsu_rdata_o = {24'h0, rx_byte_i};  // zero extended
            REGION_UART_STAT: lsu_rdata_o = stat_word;
            default:          lsu_rdata_o = '0;                  // unmapped
        endcase
    end

    // only back-pressure: data write with tx busy
    assign tx_stall   = lsu_udata & lsu_req_i.we & ~tx_ready_i;
    assign lsu_resp_o = ~tx_stall;

    assign uart_wr_o    = lsu_udata & lsu_req_i.we & tx_ready_i;
    assign uart_rd_o    = lsu_udata & ~lsu_req_i.we;  // reads never stall
    assign uart_wdata_o = lsu_req_i.wdata[7:0];       // low byte only

endmodule

`default_nettype wire

/* hw/mem_bridge_top.sv */
`timescale 1ns/10ps
`default_nettype none

module mem_bridge_top
    import bridge_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_i,

    // fetch master
    input  wire logic        fetch_req_i,
    input  wire logic [31:0] fetch_addr_i,
    output logic      [31:0] fetch_rdata_o,
    output logic             fetch_resp_o,

    // load/store master
    input  wire lsu_req_t    lsu_req_i,
    output logic      [31:0] lsu_rdata_o,
    output logic             lsu_resp_o,

    // srams
    output sram_bus_t        base_sram_o,
    input  wire logic [31:0] base_sram_rdata_i,
    output sram_bus_t        ext_sram_o,
    input  wire logic [31:0] ext_sram_rdata_i,

    // serial port, byte level
    input  wire logic        uart_rx_ready_i,
    input  wire logic [7:0]  uart_rx_data_i,
    input  wire logic        uart_tx_busy_i,
    output logic      [7:0]  uart_tx_data_o,
    output logic             uart_tx_start_o
);

    logic       uart_wr;     // arbiter -> buffer
    logic       uart_rd;
    logic [7:0] uart_wdata;
    logic [7:0] rx_byte;     // buffer -> arbiter
    logic       rx_avail;

    bus_arbiter u_arbiter (
        .fetch_req_i       (fetch_req_i),
        .fetch_addr_i      (fetch_addr_i),
        .fetch_rdata_o     (fetch_rdata_o),
        .fetch_resp_o      (fetch_resp_o),
        .lsu_req_i         (lsu_req_i),
        .lsu_rdata_o       (lsu_rdata_o),
        .lsu_resp_o        (lsu_resp_o),
        .base_sram_o       (base_sram_o),
        .base_sram_rdata_i (base_sram_rdata_i),
        .ext_sram_o        (ext_sram_o),
        .ext_sram_rdata_i  (ext_sram_rdata_i),
        .rx_byte_i         (rx_byte),
        .rx_avail_i        (rx_avail),
        .tx_ready_i        (~uart_tx_busy_i),  // ready = not busy
        .uart_wr_o         (uart_wr),
        .uart_rd_o         (uart_rd),
        .uart_wdata_o      (uart_wdata)
    );

    uart_buffer u_uart (
        .clk_i           (clk_i),
        .rst_i           (rst_i),
        .uart_wr_i       (uart_wr),
        .uart_rd_i       (uart_rd),
        .uart_wdata_i    (uart_wdata),
        .uart_rx_ready_i (uart_rx_ready_i),
        .uart_rx_data_i  (uart_rx_data_i),
        .rx_byte_o       (rx_byte),
        .rx_avail_o      (rx_avail),
        .uart_tx_data_o  (uart_tx_data_o),
        .uart_tx_start_o (uart_tx_start_o)
    );

endmodule

`default_nettype wire

/* testbench/sram_model.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bridge_settings.svh"

module sram_model
    import bridge_pkg::*;
(
    input  wire logic        clk_i,
    input  wire sram_bus_t   bus_i,
    output logic      [31:0] rdata_o
);

    logic [31:0] mem [0:(1 << `SRAM_ADDR_W)-1];  // preloaded from the testbench

    // asynchronous read, x while the chip is not driving
    assign rdata_o = (!bus_i.ce_n && !bus_i.oe_n) ? mem[bus_i.addr] : 32'hx;

    // byte-enabled write, taken on the rising edge
    always @(posedge clk_i) begin
        if (!bus_i.ce_n && !bus_i.we_n) begin
            for (int b = 0; b < 4; b++) begin
                if (!bus_i.be_n[b]) begin
                    mem[bus_i.addr][8*b +: 8] <= bus_i.wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

`default_nettype wire

/* testbench/tb_mem_bridge.sv */
`timescale 1ns/10ps
`default_nettype none

`include "bridge_settings.svh"

module tb_mem_bridge
    import bridge_pkg::*;
    import map_pkg::*;
();

    localparam int HALF = 50;       // 100 ns clock
    localparam int SETTLE = 10;     // sample point after the falling edge
    localparam int WIN = 64;        // words used in each sram
    localparam int N_FETCH = 20;
    localparam int N_RW = 24;       // writes then as many reads
    localparam int N_MIX = 40;
    localparam int N_NONE = 6;
    localparam int CYCLE_LIMIT = 4 + N_FETCH + 2 * N_RW + N_MIX + 14 + N_NONE + 50;

    logic        clk = 1'b0;
    logic        rst;
    logic        fetch_req;
    logic [31:0] fetch_addr;
    logic [31:0] fetch_rdata;
    logic        fetch_resp;
    lsu_req_t    lsu_req;
    logic [31:0] lsu_rdata;
    logic        lsu_resp;
    sram_bus_t   base_sram;
    sram_bus_t   ext_sram;
    logic [31:0] base_rdata;
    logic [31:0] ext_rdata;
    logic        uart_rx_ready;
    logic [7:0]  uart_rx_data;
    logic        uart_tx_busy;
    logic [7:0]  uart_tx_data;
    logic        uart_tx_start;

    logic [31:0] base_ref [0:WIN-1];  // model of both sram windows
    logic [31:0] ext_ref  [0:WIN-1];
    logic [7:0]  rx_byte_m;           // model of the serial buffer
    logic        rx_avail_m;
    string       cur_test;
    int          errors = 0;
    int          test_errs = 0;
    int          checks = 0;
    int          tests = 0;
    int          cycles = 0;

    always #HALF clk = ~clk;

    mem_bridge_top DUT (
        .clk_i             (clk),
        .rst_i             (rst),
        .fetch_req_i       (fetch_req),
        .fetch_addr_i      (fetch_addr),
        .fetch_rdata_o     (fetch_rdata),
        .fetch_resp_o      (fetch_resp),
        .lsu_req_i         (lsu_req),
        .lsu_rdata_o       (lsu_rdata),
        .lsu_resp_o        (lsu_resp),
        .base_sram_o       (base_sram),
        .base_sram_rdata_i (base_rdata),
        .ext_sram_o        (ext_sram),
        .ext_sram_rdata_i  (ext_rdata),
        .uart_rx_ready_i   (uart_rx_ready),
        .uart_rx_data_i    (uart_rx_data),
        .uart_tx_busy_i    (uart_tx_busy),
        .uart_tx_data_o    (uart_tx_data),
        .uart_tx_start_o   (uart_tx_start)
    );

    sram_model u_base_ram (.clk_i(clk), .bus_i(base_sram), .rdata_o(base_rdata));
    sram_model u_ext_ram  (.clk_i(clk), .bus_i(ext_sram),  .rdata_o(ext_rdata));

    // run limit sized from the test lengths
    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Something failed");
            $finish;
        end
    end

    task automatic compare(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            $display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
            test_errs++;
            errors++;
        end
    endtask

    task automatic end_test();
        tests++;
        if (test_errs == 0) $display("test %s: passed", cur_test);
        else $display("test %s: %0d mismatches", cur_test, test_errs);
        test_errs = 0;
    endtask

    // both masters change on the next falling edge
    task automatic drive(input logic f_req, input logic [31:0] f_addr, input logic valid,
                         input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                         input logic [3:0] be_n);
        @(negedge clk);
        fetch_req     = f_req;
        fetch_addr    = f_addr;
        lsu_req.valid = valid;
        lsu_req.we    = we;
        lsu_req.addr  = addr;
        lsu_req.wdata = wdata;
        lsu_req.be_n  = be_n;
    endtask

    function automatic logic [31:0] ram_addr(input logic ext, input int idx);
        return (ext ? `EXT_RAM_START : `BASE_RAM_START) + (idx << 2);
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old,
                                                input logic [31:0] wdata,
                                                input logic [3:0] be_n);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (!be_n[b]) res[8*b +: 8] = wdata[8*b +: 8];  // active low enable
        end
        return res;
    endfunction

    // load/store read data as the address map says
    function automatic logic [31:0] expected_read(input logic [31:0] addr);
        logic [31:0] stat;
        stat = '0;
        stat[`STAT_TX_READY_BIT] = !uart_tx_busy;
        stat[`STAT_RX_AVAIL_BIT] = rx_avail_m;
        case (decode_region(addr))
            REGION_BASE:      return base_ref[(addr >> 2) % WIN];
            REGION_EXT:       return ext_ref[(addr >> 2) % WIN];
            REGION_UART_DATA: return {24'h0, rx_byte_m};
            REGION_UART_STAT: return stat;
            default:          return 32'h0;
        endcase
    endfunction

    task automatic apply_write(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] be_n);
        int idx;
        idx = (addr >> 2) % WIN;
        case (decode_region(addr))
            REGION_BASE: base_ref[idx] = merge_bytes(base_ref[idx], wdata, be_n);
            REGION_EXT:  ext_ref[idx] = merge_bytes(ext_ref[idx], wdata, be_n);
            default:     ;
        endcase
    endtask

    initial begin
        int unsigned seed_val;
        int          idx;
        int          fidx;
        logic        we;
        logic        valid;
        logic        exp_fresp;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [7:0]  data_byte;

        seed_val = $urandom(32'hab08);
        rst = 1'b1;
        fetch_req = 1'b0;
        fetch_addr = '0;
        lsu_req = '0;
        uart_rx_ready = 1'b0;
        uart_rx_data = '0;
        uart_tx_busy = 1'b0;
        rx_byte_m = '0;
        rx_avail_m = 1'b0;
        for (int i = 0; i < WIN; i++) begin
            base_ref[i] = $urandom;
            ext_ref[i] = $urandom;
            u_base_ram.mem[i] = base_ref[i];
            u_ext_ram.mem[i] = ext_ref[i];
        end
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        cur_test = "fetch";  // load/store idle
        repeat (N_FETCH) begin
            idx = $urandom % WIN;
            drive(1'b1, ram_addr(1'b0, idx), 1'b0, 1'b0, '0, '0, '0);
            #SETTLE;
            compare("fetch_resp", 1, fetch_resp);
            compare("fetch_rdata", base_ref[idx], fetch_rdata);
            compare("base_be_n", 0, base_sram.be_n);  // whole word
        end
        end_test();

        cur_test = "lsu_rw";
        for (int pass = 0; pass < 2; pass++) begin
            repeat (N_RW) begin
                addr = ram_addr($urandom % 2, $urandom % WIN);
                wdata = $urandom;
                drive(1'b0, '0, 1'b1, pass == 0, addr, wdata, $urandom);
                #SETTLE;
                compare("lsu_resp", 1, lsu_resp);
                if (pass == 0) apply_write(addr, wdata, lsu_req.be_n);
                else compare("lsu_rdata", expected_read(addr), lsu_rdata);
            end
        end
        end_test();

        cur_test = "mixed";  // both masters with random targets
        repeat (N_MIX) begin
            fidx = $urandom % WIN;
            idx = $urandom % 3;
            addr = (idx == 2) ? `UART_STAT_ADDR : ram_addr(idx == 1, $urandom % WIN);
            we = (idx != 2) && ($urandom % 2);
            valid = $urandom % 2;
            wdata = $urandom;
            drive(($urandom % 4) != 0, ram_addr(1'b0, fidx), valid, we, addr, wdata, $urandom);
            #SETTLE;
            exp_fresp = fetch_req && !(valid && decode_region(addr) == REGION_BASE);
            compare("fetch_resp", exp_fresp, fetch_resp);
            if (exp_fresp) compare("fetch_rdata", base_ref[fidx], fetch_rdata);
            if (valid) begin
                compare("lsu_resp", 1, lsu_resp);
                if (we) apply_write(addr, wdata, lsu_req.be_n);
                else compare("lsu_rdata", expected_read(addr), lsu_rdata);
            end
        end
        end_test();

        cur_test = "uart_tx";
        data_byte = $urandom;
        wdata = $urandom;
        wdata[7:0] = data_byte;  // random upper bytes
        drive(1'b0, '0, 1'b1, 1'b1, `UART_DATA_ADDR, wdata, '0);
        #SETTLE;
        compare("lsu_resp", 1, lsu_resp);
        drive(1'b0, '0, 1'b0, 1'b0, '0, '0, '0);
        #SETTLE;
        compare("tx_start", 1, uart_tx_start);  // exactly one cycle
        compare("tx_data", data_byte, uart_tx_data);
        data_byte = $urandom;
        drive(1'b0, '0, 1'b1, 1'b1, `UART_DATA_ADDR, {24'h0, data_byte}, '0);
        uart_tx_busy = 1'b1;
        #SETTLE;
        compare("tx_start", 0, uart_tx_start);
        compare("lsu_resp", 0, lsu_resp);  // held off while busy
        @(negedge clk);
        #SETTLE;
        compare("tx_start", 0, uart_tx_start);
        compare("lsu_resp", 0, lsu_resp);
        @(negedge clk);
        uart_tx_busy = 1'b0;  // master still holds the write
        #SETTLE;
        compare("lsu_resp", 1, lsu_resp);
        drive(1'b0, '0, 1'b0, 1'b0, '0, '0, '0);
        #SETTLE;
        compare("tx_start", 1, uart_tx_start);
        compare("tx_data", data_byte, uart_tx_data);
        end_test();

        cur_test = "uart_rx";
        drive(1'b0, '0, 1'b1, 1'b0, `UART_STAT_ADDR, '0, '0);
        data_byte = $urandom;
        uart_rx_ready = 1'b1;
        uart_rx_data = data_byte;
        #SETTLE;
        compare("status", expected_read(`UART_STAT_ADDR), lsu_rdata);  // nothing waiting
        drive(1'b0, '0, 1'b1, 1'b0, `UART_STAT_ADDR, '0, '0);
        uart_rx_ready = 1'b0;
        rx_byte_m = data_byte;
        rx_avail_m = 1'b1;
        #SETTLE;
        compare("status", expected_read(`UART_STAT_ADDR), lsu_rdata);
        drive(1'b0, '0, 1'b1, 1'b0, `UART_DATA_ADDR, '0, '0);
        #SETTLE;
        compare("rx_data", expected_read(`UART_DATA_ADDR), lsu_rdata);
        rx_avail_m = 1'b0;  // consumed by that read
        drive(1'b0, '0, 1'b1, 1'b0, `UART_STAT_ADDR, '0, '0);
        #SETTLE;
        compare("status", expected_read(`UART_STAT_ADDR), lsu_rdata);
        end_test();

        cur_test = "unmapped";
        repeat (N_NONE) begin
            addr = $urandom;
            while (decode_region(addr) != REGION_NONE) addr = $urandom;
            drive(1'b0, '0, 1'b1, $urandom % 2, addr, $urandom, $urandom);
            #SETTLE;
            compare("lsu_resp", 1, lsu_resp);
            if (!lsu_req.we) compare("lsu_rdata", 0, lsu_rdata);
            compare("base_ce_n", 1, base_sram.ce_n);
            compare("ext_ce_n", 1, ext_sram.ce_n);
            compare("base_we_n", 1, base_sram.we_n);
            compare("ext_we_n", 1, ext_sram.we_n);
        end
        end_test();

        drive(1'b0, '0, 1'b0, 1'b0, '0, '0, '0);
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+hw
hw/bridge_pkg.sv
hw/map_pkg.sv
hw/uart_buffer.sv
hw/bus_arbiter.sv
hw/mem_bridge_top.sv
testbench/sram_model.sv
testbench/tb_mem_bridge.sv
